// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module rv_mem_wb_tb -o rv_mem_wb_sim

out=$(./obj_dir/rv_mem_wb_sim)
echo "$out"

if echo "$out" | grep -qx ">>> PASS"; then
    exit 0
fi
exit 1

// File: sim.f
src/rv_pkg.sv
src/rv_mem_stage.sv
src/rv_data_mem.sv
src/rv_write.sv
src/rv_reg_file.sv
src/rv_mem_wb_top.sv
test/rv_mem_wb_asserts.sv
test/rv_mem_wb_checker.sv
test/rv_mem_wb_tb.sv

// File: src/rv_data_mem.sv
`timescale 1ns/1ps

module rv_data_mem
(
    input  logic                          i_clk,
    input  logic [rv_pkg::MEM_ADDR_W-1:0] i_addr,
    input  logic [rv_pkg::BE_W-1:0]       i_be,
    input  logic [rv_pkg::XLEN-1:0]       i_wdata,
    input  logic                          i_write,
    output logic [rv_pkg::XLEN-1:0]       o_rdata
);
    import rv_pkg::*;

    logic [XLEN-1:0] mem [0:MEM_WORDS-1];

    // Byte lanes merge into the stored word
    always_ff @(posedge i_clk)
    begin
        if (i_write)
        begin
            for (int lane = 0; lane < BE_W; lane++)
            begin
                if (i_be[lane])
                begin
                    mem[i_addr][lane*8 +: 8] <= i_wdata[lane*8 +: 8];
                end
            end
        end
    end

    assign o_rdata = mem[i_addr];                   // Same-cycle read

endmodule

// File: src/rv_mem_stage.sv
`timescale 1ns/1ps

module rv_mem_stage
(
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_reg_write,
    input  logic                          i_mem_write,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd,
    input  rv_pkg::funct3_t               i_funct3,
    input  rv_pkg::res_src_t              i_res_src,
    input  logic [rv_pkg::XLEN-1:0]       i_alu_result,
    input  logic [rv_pkg::XLEN-1:0]       i_store_data,
    output logic [rv_pkg::MEM_ADDR_W-1:0] o_mem_addr,
    output logic [rv_pkg::BE_W-1:0]       o_mem_be,
    output logic [rv_pkg::XLEN-1:0]       o_mem_wdata,
    output logic                          o_mem_write,
    output logic [rv_pkg::XLEN-1:0]       o_alu_result,
    output rv_pkg::funct3_t               o_funct3,
    output rv_pkg::res_src_t              o_res_src,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rd,
    output logic                          o_reg_write
);
    import rv_pkg::*;

    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       store_data;
    funct3_t               funct3;
    res_src_t              res_src;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_write;
    logic                  mem_write;
    logic [1:0]            byte_off;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            reg_write <= 1'b0;
            mem_write <= 1'b0;
        end
        else
        begin
            reg_write <= i_reg_write;
            mem_write <= i_mem_write;
        end
    end

    always_ff @(posedge i_clk)
    begin
        alu_result <= i_alu_result;
        store_data <= i_store_data;
        funct3     <= i_funct3;
        res_src    <= i_res_src;
        rd         <= i_rd;
    end

    assign byte_off = alu_result[1:0];

    // Place store data on the lanes picked by the low address bits
    always_comb
    begin
        case (funct3)
            SB:
            begin
                o_mem_be    = BE_W'(1) << byte_off;
                o_mem_wdata = {BE_W{store_data[7:0]}};
            end
            SH:
            begin
                o_mem_be    = byte_off[1] ? 4'b1100 : 4'b0011;  // Bit 0 ignored
                o_mem_wdata = {(BE_W / 2){store_data[15:0]}};
            end
            SW:
            begin
                o_mem_be    = '1;
                o_mem_wdata = store_data;
            end
            default:
            begin
                o_mem_be    = '0;                               // Reserved, no lanes
                o_mem_wdata = store_data;
            end
        endcase
    end

    assign o_mem_addr   = alu_result[MEM_ADDR_W+1:2];
    assign o_mem_write  = mem_write;
    assign o_alu_result = alu_result;
    assign o_funct3     = funct3;
    assign o_res_src    = res_src;
    assign o_rd         = rd;
    assign o_reg_write  = reg_write;

endmodule

// File: src/rv_mem_wb_top.sv
`timescale 1ns/1ps

module rv_mem_wb_top
(
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_reg_write,
    input  logic                          i_mem_write,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd,
    input  rv_pkg::funct3_t               i_funct3,
    input  rv_pkg::res_src_t              i_res_src,
    input  logic [rv_pkg::XLEN-1:0]       i_alu_result,
    input  logic [rv_pkg::XLEN-1:0]       i_store_data,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_dbg_addr,
    output logic [rv_pkg::XLEN-1:0]       o_dbg_data,
    output logic                          o_wb_write,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_wb_rd,
    output logic [rv_pkg::XLEN-1:0]       o_wb_data
);
    import rv_pkg::*;

    logic [MEM_ADDR_W-1:0] mem_addr;
    logic [BE_W-1:0]       mem_be;
    logic [XLEN-1:0]       mem_wdata;
    logic                  mem_write;
    logic [XLEN-1:0]       mem_rdata;
    logic [XLEN-1:0]       ms_alu_result;
    funct3_t               ms_funct3;
    res_src_t              ms_res_src;
    logic [REG_ADDR_W-1:0] ms_rd;
    logic                  ms_reg_write;

    rv_mem_stage u_mem_stage
    (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_reg_write  (i_reg_write),
        .i_mem_write  (i_mem_write),
        .i_rd         (i_rd),
        .i_funct3     (i_funct3),
        .i_res_src    (i_res_src),
        .i_alu_result (i_alu_result),
        .i_store_data (i_store_data),
        .o_mem_addr   (mem_addr),
        .o_mem_be     (mem_be),
        .o_mem_wdata  (mem_wdata),
        .o_mem_write  (mem_write),
        .o_alu_result (ms_alu_result),
        .o_funct3     (ms_funct3),
        .o_res_src    (ms_res_src),
        .o_rd         (ms_rd),
        .o_reg_write  (ms_reg_write)
    );

    rv_data_mem u_data_mem
    (
        .i_clk   (i_clk),
        .i_addr  (mem_addr),
        .i_be    (mem_be),
        .i_wdata (mem_wdata),
        .i_write (mem_write),
        .o_rdata (mem_rdata)
    );

    rv_write u_write
    (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_funct3     (ms_funct3),
        .i_alu_result (ms_alu_result),
        .i_reg_write  (ms_reg_write),
        .i_rd         (ms_rd),
        .i_res_src    (ms_res_src),
        .i_data       (mem_rdata),
        .o_data       (o_wb_data),
        .o_rd         (o_wb_rd),
        .o_write_op   (o_wb_write)
    );

    // Write port carries the same signals seen on the o_wb outputs
    rv_reg_file u_reg_file
    (
        .i_clk   (i_clk),
        .i_write (o_wb_write),
        .i_waddr (o_wb_rd),
        .i_wdata (o_wb_data),
        .i_raddr (i_dbg_addr),
        .o_rdata (o_dbg_data)
    );

endmodule

// File: src/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;
    localparam int MEM_ADDR_W = 8;                  // Word index, 256 words
    localparam int MEM_WORDS  = 1 << MEM_ADDR_W;
    localparam int BE_W       = XLEN / 8;

    // Load and store width codes, taken from the instruction funct3 field
    typedef enum logic [2:0]
    {
        LB   = 3'd0,
        LH   = 3'd1,
        LW   = 3'd2,
        RSV3 = 3'd3,
        LBU  = 3'd4,
        LHU  = 3'd5,
        RSV6 = 3'd6,
        RSV7 = 3'd7
    } funct3_t;

    // Stores share the low three codes with the signed loads
    localparam funct3_t SB = LB;
    localparam funct3_t SH = LH;
    localparam funct3_t SW = LW;

    typedef enum logic [1:0]
    {
        RES_ALU     = 2'd0,
        RES_MEM     = 2'd1,
        RES_PC_NEXT = 2'd2                          // Next PC already in ALU result
    } res_src_t;

endpackage

// File: src/rv_reg_file.sv
`timescale 1ns/1ps

module rv_reg_file
(
    input  logic                          i_clk,
    input  logic                          i_write,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_waddr,
    input  logic [rv_pkg::XLEN-1:0]       i_wdata,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_raddr,
    output logic [rv_pkg::XLEN-1:0]       o_rdata
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [0:NUM_REGS-1];

    always_ff @(posedge i_clk)
    begin
        if (i_write && (i_waddr != '0))             // x0 never written
        begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // x0 reads as zero whatever its storage holds
    always_comb
    begin
        if (i_raddr == '0)
        begin
            o_rdata = '0;
        end
        else
        begin
            o_rdata = regs[i_raddr];
        end
    end

endmodule

// File: src/rv_write.sv
`timescale 1ns/1ps

module rv_write
(
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  rv_pkg::funct3_t               i_funct3,
    input  logic [rv_pkg::XLEN-1:0]       i_alu_result,
    input  logic                          i_reg_write,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd,
    input  rv_pkg::res_src_t              i_res_src,
    input  logic [rv_pkg::XLEN-1:0]       i_data,
    output logic [rv_pkg::XLEN-1:0]       o_data,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rd,
    output logic                          o_write_op
);
    import rv_pkg::*;

    logic [XLEN-1:0]       alu_result;
    res_src_t              res_src;
    logic                  reg_write;
    logic [REG_ADDR_W-1:0] rd;
    funct3_t               funct3;
    logic [XLEN-1:0]       rdata;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            reg_write <= 1'b0;
        end
        else
        begin
            reg_write <= i_reg_write;
        end
    end

    always_ff @(posedge i_clk)
    begin
        alu_result <= i_alu_result;
        res_src    <= i_res_src;
        rd         <= i_rd;
        funct3     <= i_funct3;
        rdata      <= i_data;                       // Word read during the memory stage
    end

    logic [7:0]      load_byte;
    logic [15:0]     load_half;
    logic [XLEN-1:0] load_data;

    always_comb
    begin
        case (alu_result[1:0])
            2'b00: load_byte = rdata[0  +: 8];
            2'b01: load_byte = rdata[8  +: 8];
            2'b10: load_byte = rdata[16 +: 8];
            2'b11: load_byte = rdata[24 +: 8];
        endcase
    end

    assign load_half = alu_result[1] ? rdata[16 +: 16] : rdata[0 +: 16];

    always_comb
    begin
        case (funct3)
            LB:      load_data = {{24{load_byte[7]}}, load_byte};
            LH:      load_data = {{16{load_half[15]}}, load_half};
            LW:      load_data = rdata;
            LBU:     load_data = {24'd0, load_byte};
            LHU:     load_data = {16'd0, load_half};
            default: load_data = '0;                // Reserved codes
        endcase
    end

    always_comb
    begin
        case (res_src)
            RES_MEM:     o_data = load_data;
            RES_ALU,
            RES_PC_NEXT: o_data = alu_result;
            default:     o_data = alu_result;
        endcase
    end

    assign o_rd       = rd;
    assign o_write_op = reg_write;

endmodule

// File: test/rv_mem_wb_asserts.sv
`timescale 1ns/1ps

module rv_mem_wb_asserts
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_wb_write,
    input  logic                    i_mem_write,
    input  logic [rv_pkg::BE_W-1:0] i_mem_be,
    input  rv_pkg::funct3_t         i_funct3
);
    import rv_pkg::*;

    wb_low_after_reset: assert property (@(posedge i_clk) !i_rst_n |=> !i_wb_write)
        else $error("Writeback strobe high in the cycle after reset");

    // The strobe flop clears at the first reset edge
    mem_write_held_in_reset: assert property (@(posedge i_clk) !i_rst_n |=> !i_mem_write)
        else $error("Memory write strobe high during reset");

    sb_one_hot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_mem_write && i_funct3 == SB) |-> $onehot(i_mem_be))
        else $error("Byte store enables are not one-hot");

    sh_aligned_pair: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_mem_write && i_funct3 == SH) |-> (i_mem_be == 4'b0011 || i_mem_be == 4'b1100))
        else $error("Halfword store enables are not an aligned pair");

    sw_all_lanes: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_mem_write && i_funct3 == SW) |-> (i_mem_be == 4'b1111))
        else $error("Word store does not enable all lanes");

endmodule

// File: test/rv_mem_wb_checker.sv
`timescale 1ns/1ps

module rv_mem_wb_checker
(
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_reg_write,
    input  logic                          i_mem_write,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd,
    input  rv_pkg::funct3_t               i_funct3,
    input  rv_pkg::res_src_t              i_res_src,
    input  logic [rv_pkg::XLEN-1:0]       i_alu_result,
    input  logic [rv_pkg::XLEN-1:0]       i_store_data,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_dbg_addr,
    input  logic [rv_pkg::XLEN-1:0]       i_dbg_data,
    input  logic                          i_wb_write,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_wb_rd,
    input  logic [rv_pkg::XLEN-1:0]       i_wb_data,
    output int                            o_errors,
    output int                            o_checks,
    output logic                          o_idle
);
    import rv_pkg::*;

    logic [XLEN-1:0]       mem_model [0:MEM_WORDS-1];
    logic [XLEN-1:0]       reg_model [0:NUM_REGS-1];
    int                    errors = 0;
    int                    checks = 0;
    // Expected writeback one edge in (s1) and on the outputs (s2)
    logic                  s1_known = 1'b0;
    logic                  s1_write = 1'b0;
    logic [REG_ADDR_W-1:0] s1_rd;
    logic [XLEN-1:0]       s1_data;
    string                 s1_name;
    logic                  s2_known = 1'b0;
    logic                  s2_write = 1'b0;
    logic [REG_ADDR_W-1:0] s2_rd;
    logic [XLEN-1:0]       s2_data;
    string                 s2_name;

    function automatic logic [XLEN-1:0] load_value(input logic [XLEN-1:0] word,
                                                   input logic [1:0] off, input funct3_t f3);
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] h;
        b = word >> (8 * off);
        h = word >> (16 * off[1]);
        case (f3)
            LB:      return {{24{b[7]}}, b[7:0]};
            LH:      return {{16{h[15]}}, h[15:0]};
            LW:      return word;
            LBU:     return {24'd0, b[7:0]};
            LHU:     return {16'd0, h[15:0]};
            default: return '0;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] store_merge(input logic [XLEN-1:0] word,
        input logic [1:0] off, input funct3_t f3, input logic [XLEN-1:0] data);
        logic [XLEN-1:0] mask;
        logic [XLEN-1:0] lanes;
        mask  = '0;
        lanes = '0;
        if (f3 == SB)
        begin
            mask  = 32'h0000_00ff << (8 * off);
            lanes = {24'd0, data[7:0]} << (8 * off);
        end
        else if (f3 == SH)
        begin
            mask  = 32'h0000_ffff << (16 * off[1]);
            lanes = {16'd0, data[15:0]} << (16 * off[1]);
        end
        else if (f3 == SW)
        begin
            mask  = '1;
            lanes = data;
        end
        return (word & ~mask) | (lanes & mask);
    endfunction

    task automatic compare_value(input string name, input logic [XLEN-1:0] expected,
                                 input logic [XLEN-1:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAIL %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    always @(posedge i_clk)
    begin
        logic [MEM_ADDR_W-1:0] idx;
        logic [XLEN-1:0]       word;
        if (s2_known && s2_write && (s2_rd != '0))  // Register file write at this edge
        begin
            reg_model[s2_rd] = s2_data;
        end
        s2_known = s1_known;
        s2_write = i_rst_n && s1_write;
        s2_rd    = s1_rd;
        s2_data  = s1_data;
        s2_name  = s1_name;
        if (!i_rst_n)
        begin
            s1_known = 1'b0;
            s1_write = 1'b0;
        end
        else
        begin
            idx      = i_alu_result[MEM_ADDR_W+1:2];
            word     = mem_model[idx];
            s1_known = 1'b1;
            s1_write = i_reg_write;
            s1_rd    = i_rd;
            if (i_res_src == RES_MEM)
            begin
                s1_data = load_value(word, i_alu_result[1:0], i_funct3);
                s1_name = $sformatf("load %s", i_funct3.name());
            end
            else
            begin
                s1_data = i_alu_result;
                s1_name = i_res_src.name();
            end
            if (i_mem_write)                        // Own load already read the old word
                mem_model[idx] = store_merge(word, i_alu_result[1:0], i_funct3, i_store_data);
        end
    end

    always @(negedge i_clk)
    begin
        logic [XLEN-1:0] dbg_expected;
        dbg_expected = (i_dbg_addr == '0) ? '0 : reg_model[i_dbg_addr];
        compare_value("wb_write", 32'(s2_write), 32'(i_wb_write));
        if (s2_known)
        begin
            compare_value($sformatf("wb_rd (%s)", s2_name), 32'(s2_rd), 32'(i_wb_rd));
            compare_value($sformatf("wb_data (%s)", s2_name), s2_data, i_wb_data);
        end
        compare_value($sformatf("dbg_read x%0d", i_dbg_addr), dbg_expected, i_dbg_data);
    end

    assign o_errors = errors;
    assign o_checks = checks;
    assign o_idle   = !(s1_write || s2_write);

endmodule

// File: test/rv_mem_wb_tb.sv
`timescale 1ns/1ps

module rv_mem_wb_tb;
    import rv_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int NUM_OPS      = 2000;
    localparam int DRAIN_LIMIT  = 16;

    logic                  i_clk = 1'b0;
    logic                  i_rst_n;
    logic                  i_reg_write;
    logic                  i_mem_write;
    logic [REG_ADDR_W-1:0] i_rd;
    funct3_t               i_funct3;
    res_src_t              i_res_src;
    logic [XLEN-1:0]       i_alu_result;
    logic [XLEN-1:0]       i_store_data;
    logic [REG_ADDR_W-1:0] i_dbg_addr;
    logic [XLEN-1:0]       o_dbg_data;
    logic                  o_wb_write;
    logic [REG_ADDR_W-1:0] o_wb_rd;
    logic [XLEN-1:0]       o_wb_data;
    logic [31:0]           seed;
    int                    errors;
    int                    checks;
    logic                  idle;
    logic                  drain_ok;

    always #10 i_clk = ~i_clk;                      // 20 ns period

    rv_mem_wb_top dut0 (.*);

    rv_mem_wb_checker u_checker
    (
        .*,
        .i_dbg_data (o_dbg_data),
        .i_wb_write (o_wb_write),
        .i_wb_rd    (o_wb_rd),
        .i_wb_data  (o_wb_data),
        .o_errors   (errors),
        .o_checks   (checks),
        .o_idle     (idle)
    );

    bind rv_mem_wb_top rv_mem_wb_asserts u_asserts
    (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wb_write  (o_wb_write),
        .i_mem_write (mem_write),
        .i_mem_be    (mem_be),
        .i_funct3    (ms_funct3)
    );

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [XLEN-1:0] fill_word(input logic [7:0] w);
        return {~w, w ^ 8'h5a, w, w + 8'h3c};
    endfunction

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++)
        begin
            @(posedge i_clk);
            #1;
        end
    endtask

    task automatic drive_op(input logic rw, input logic mw, input logic [REG_ADDR_W-1:0] rd,
                            input funct3_t f3, input res_src_t src,
                            input logic [XLEN-1:0] alu, input logic [XLEN-1:0] sd);
        i_reg_write  = rw;
        i_mem_write  = mw;
        i_rd         = rd;
        i_funct3     = f3;
        i_res_src    = src;
        i_alu_result = alu;
        i_store_data = sd;
    endtask

    task automatic random_op();
        logic [31:0] r;
        logic [31:0] addr;
        logic [1:0]  st_code;
        r          = next_rand();
        addr       = next_rand() & 32'h0000_03ff;
        st_code    = (r[26:25] == 2'd3) ? 2'd2 : r[26:25];
        i_dbg_addr = r[9:5];
        if (r[20])
            addr = addr & 32'h0000_001f;            // Small window, many store-load hits
        case (r[31:30])
            2'd0: drive_op(r[12], 1'b1, r[17:13], funct3_t'({1'b0, st_code}), RES_ALU,
                           addr, next_rand());
            2'd3: drive_op(r[12], 1'b0, r[17:13], funct3_t'(r[27:25]),
                           r[11] ? RES_PC_NEXT : RES_ALU, next_rand(), next_rand());
            default: drive_op(1'b1, 1'b0, r[17:13], funct3_t'(r[27:25]), RES_MEM,
                              addr, next_rand());
        endcase
    endtask

    task automatic wait_idle(output logic ok);
        int cycles;
        cycles = 0;
        while (!idle && cycles < DRAIN_LIMIT)
        begin
            wait_cycles(1);
            cycles++;
        end
        ok = idle;
    endtask

    initial
    begin
        seed       = 32'hae67_fb8e;
        i_rst_n    = 1'b0;
        i_dbg_addr = '0;
        drive_op(1'b0, 1'b0, '0, LW, RES_ALU, '0, '0);
        wait_cycles(RESET_CYCLES);
        i_rst_n = 1'b1;
        for (int w = 0; w < MEM_WORDS; w++)
        begin
            drive_op(1'b0, 1'b1, '0, SW, RES_ALU, 32'(w) << 2, fill_word(w[7:0]));
            wait_cycles(1);
        end
        for (int r = 0; r < NUM_REGS; r++)          // x0 gets a write too
        begin
            drive_op(1'b1, 1'b0, r[4:0], LW, RES_ALU, next_rand(), '0);
            wait_cycles(1);
        end
        for (int n = 0; n < NUM_OPS; n++)
        begin
            random_op();
            wait_cycles(1);
        end
        drive_op(1'b0, 1'b0, '0, LW, RES_ALU, '0, '0);
        wait_idle(drain_ok);
        if (drain_ok)
        begin
            for (int a = 0; a < NUM_REGS; a++)
            begin
                i_dbg_addr = a[4:0];
                wait_cycles(1);
            end
        end
        else
        begin
            $display("Timeout: writeback pipeline did not drain in %0d cycles", DRAIN_LIMIT);
        end
        $display("Run finished: %0d checks, %0d errors", checks, errors);
        if (drain_ok && errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
